// File: rtl/decode_cfg.svh
/*
 * decode stage configuration macros
 * - datapath and register file sizes
 * - opcode values of the supported subset
 * - function value of jr
 */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath sizes
`define DATA_W     32
`define REG_COUNT  32
`define REG_AW     5

// primary opcodes, instr[31:26]
`define OP_RTYPE   6'h00
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDI    6'h08
`define OP_SLTI    6'h0a
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LB      6'h20
`define OP_LH      6'h21
`define OP_LW      6'h23
`define OP_SW      6'h2b

// function field of the register jump, instr[5:0]
`define FN_JR      6'h08

`endif

// File: rtl/decode_pkg.sv
/*
 * shared types of the decode stage
 * - width typedefs for words, register indices, alu codes
 * - enums for load, branch, jump and forwarding kinds
 * - packed bundles for control, operands, the id/ex register,
 *   the writeback port and the hazard inputs
 */
`default_nettype none

`include "decode_cfg.svh"

package decode_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;
	// function field for r-type, opcode for the rest
	typedef logic [5:0]         alu_op_t;

	typedef enum logic [1:0] {LOAD_WORD, LOAD_HALF, LOAD_BYTE} load_kind_t;
	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_kind_t;
	typedef enum logic [1:0] {JMP_NONE, JMP_J, JMP_JAL, JMP_JR} jump_kind_t;
	// operand source picked in execute
	typedef enum logic [1:0] {FWD_REG, FWD_EXE, FWD_MEM} fwd_sel_t;

	// ========================================================================
	// pipeline bundles
	// ========================================================================
	typedef struct packed {
		alu_op_t    alu_op;
		logic       alu_src;     // second operand is the immediate
		logic       reg_dst;     // destination is rd, not rt
		logic       mem_read;
		logic       mem_write;
		load_kind_t load_kind;
		logic       mem_to_reg;
		logic       reg_write;
		logic       link;        // jal writes pc+8
	} ctrl_t;

	typedef struct packed {
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm_ext;
		word_t     branch_target;
		reg_addr_t rt_addr;
		reg_addr_t rd_addr;
		fwd_sel_t  fwd_a;
		fwd_sel_t  fwd_b;
	} operands_t;

	typedef struct packed {
		ctrl_t        ctrl;
		operands_t    ops;
		word_t        pc4;
		branch_kind_t branch;
	} id_ex_t;

	// write request coming back from writeback
	typedef struct packed {
		logic      we;
		reg_addr_t addr;
		word_t     data;
	} wb_port_t;

	// destinations still in flight in execute and memory
	typedef struct packed {
		reg_addr_t exe_dst;
		logic      exe_reg_write;
		reg_addr_t mem_dst;
		logic      mem_reg_write;
	} hazard_t;

endpackage

`default_nettype wire

// File: rtl/control_decoder.sv
/*
 * control decoder of the decode stage
 * - opcode / function case table into the control bundle
 * - branch kind, jump kind and fetch stall
 * - sign-extend select for the immediate
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module control_decoder (
	input  decode_pkg::word_t        i_instr,
	output decode_pkg::ctrl_t        o_ctrl,
	output decode_pkg::branch_kind_t o_branch,
	output decode_pkg::jump_kind_t   o_jump,
	output logic                     o_sign_ext,
	output logic                     o_ifstall
);

	import decode_pkg::*;

	alu_op_t opcode;
	alu_op_t funct;

	assign opcode = i_instr[31:26];
	assign funct  = i_instr[5:0];

	// ========================================================================
	// decode table
	// ========================================================================
	always_comb begin
		// everything idle unless the table says otherwise
		o_ctrl   = '0;
		o_branch = BR_NONE;
		o_jump   = JMP_NONE;
		case (opcode)
			`OP_RTYPE: begin
				if (funct == `FN_JR) begin
					// register jump, nothing to write back
					o_jump = JMP_JR;
				end else if (i_instr != '0) begin
					// all-zero word is the fetch nop and stays idle
					o_ctrl.alu_op    = funct;
					o_ctrl.reg_dst   = 1'b1;
					o_ctrl.reg_write = 1'b1;
				end
			end
			`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI: begin
				o_ctrl.alu_op    = opcode;
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.reg_write = 1'b1;
			end
			`OP_LB, `OP_LH, `OP_LW: begin
				o_ctrl.alu_op     = opcode;
				o_ctrl.alu_src    = 1'b1;
				o_ctrl.mem_read   = 1'b1;
				o_ctrl.mem_to_reg = 1'b1;
				o_ctrl.reg_write  = 1'b1;
				// size of the loaded value
				case (opcode)
					`OP_LB:  o_ctrl.load_kind = LOAD_BYTE;
					`OP_LH:  o_ctrl.load_kind = LOAD_HALF;
					default: o_ctrl.load_kind = LOAD_WORD;
				endcase
			end
			`OP_SW: begin
				o_ctrl.alu_op    = opcode;
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.mem_write = 1'b1;
			end
			`OP_BEQ: begin
				o_ctrl.alu_op = opcode;
				o_branch      = BR_EQ;
			end
			`OP_BNE: begin
				o_ctrl.alu_op = opcode;
				o_branch      = BR_NE;
			end
			`OP_J: begin
				o_ctrl.alu_op = opcode;
				o_jump        = JMP_J;
			end
			`OP_JAL: begin
				// return address pc+8, r31 picked in writeback
				o_ctrl.alu_op    = opcode;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.link      = 1'b1;
				o_jump           = JMP_JAL;
			end
			default: begin
				// unknown opcode keeps the idle defaults
			end
		endcase
	end

	// logical immediates are zero extended
	assign o_sign_ext = !((opcode == `OP_ANDI) || (opcode == `OP_ORI));

	// fetch waits on any change of flow
	assign o_ifstall = (o_branch != BR_NONE) || (o_jump != JMP_NONE);

	// a memory access is either a load or a store
	a_mem_excl : assert final (!(o_ctrl.mem_read && o_ctrl.mem_write))
		else $error("mem_read and mem_write both set");

endmodule

`default_nettype wire

// File: rtl/register_bank.sv
/*
 * register bank
 * - 32 x 32-bit storage, register 0 hard-wired to zero
 * - two read ports with write-through from writeback
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module register_bank (
	input  logic                 i_clk,
	input  logic                 i_nrst,
	input  decode_pkg::reg_addr_t i_rs_addr,
	input  decode_pkg::reg_addr_t i_rt_addr,
	input  decode_pkg::wb_port_t  i_wb,
	output decode_pkg::word_t     o_rs_data,
	output decode_pkg::word_t     o_rt_data
);

	import decode_pkg::*;

	// no storage behind register 0
	word_t regs [1:`REG_COUNT-1];

	// zero register, then writeback bypass, then storage
	function automatic word_t read_port(input reg_addr_t addr);
		word_t value;
		if (addr == '0) begin
			value = '0;
		end else if (i_wb.we && (i_wb.addr == addr)) begin
			value = i_wb.data;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb.we && (i_wb.addr != '0)) begin
			regs[i_wb.addr] <= i_wb.data;
		end
	end

	always_comb begin
		o_rs_data = read_port(i_rs_addr);
		o_rt_data = read_port(i_rt_addr);
	end

	// writeback must name its target whenever it writes
	a_wb_addr_known : assert property (
		@(posedge i_clk) disable iff (!i_nrst)
		i_wb.we |-> !$isunknown(i_wb.addr)
	) else $error("writeback address unknown during write");

endmodule

`default_nettype wire

// File: rtl/operand_unit.sv
/*
 * operand unit of the decode stage
 * - register bank reads for rs and rt
 * - immediate extension and branch target adder
 * - forwarding source select for both operands
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module operand_unit (
	input  logic                  i_clk,
	input  logic                  i_nrst,
	input  decode_pkg::word_t     i_instr,
	input  decode_pkg::word_t     i_pc4,
	input  logic                  i_sign_ext,
	input  decode_pkg::wb_port_t  i_wb,
	input  decode_pkg::hazard_t   i_hazard,
	output decode_pkg::operands_t o_ops
);

	import decode_pkg::*;

	reg_addr_t   rs_addr;
	logic [15:0] imm;
	word_t       imm_ext;

	// execute wins over memory, r0 and idle stages never forward
	function automatic fwd_sel_t fwd_select(input reg_addr_t src, input hazard_t hz);
		fwd_sel_t sel;
		if (hz.exe_reg_write && (hz.exe_dst != '0) && (hz.exe_dst == src)) begin
			sel = FWD_EXE;
		end else if (hz.mem_reg_write && (hz.mem_dst != '0) && (hz.mem_dst == src)) begin
			sel = FWD_MEM;
		end else begin
			sel = FWD_REG;
		end
		return sel;
	endfunction

	// instruction fields
	assign rs_addr       = i_instr[25:21];
	assign o_ops.rt_addr = i_instr[20:16];
	assign o_ops.rd_addr = i_instr[15:11];
	assign imm           = i_instr[15:0];

	register_bank register_bank_inst (
		.i_clk     (i_clk),
		.i_nrst    (i_nrst),
		.i_rs_addr (rs_addr),
		.i_rt_addr (o_ops.rt_addr),
		.i_wb      (i_wb),
		.o_rs_data (o_ops.rs_data),
		.o_rt_data (o_ops.rt_data)
	);

	// ========================================================================
	// immediate and branch target
	// ========================================================================
	// lui keeps the low-half form, the alu shifts it up
	assign imm_ext = i_sign_ext ? {{(`DATA_W-16){imm[15]}}, imm}
	                            : {{(`DATA_W-16){1'b0}}, imm};
	assign o_ops.imm_ext = imm_ext;

	// word offset relative to pc+4
	assign o_ops.branch_target = i_pc4 + (imm_ext << 2);

	// forwarding for operand a (rs) and b (rt)
	assign o_ops.fwd_a = fwd_select(rs_addr, i_hazard);
	assign o_ops.fwd_b = fwd_select(o_ops.rt_addr, i_hazard);

endmodule

`default_nettype wire

// File: rtl/id_ex_register.sv
/*
 * decode/execute pipeline register
 * - control, branch kind, operands and pc+4 in one bundle
 * - cleared to an idle bundle on reset
 */
`timescale 1ns/1ps
`default_nettype none

module id_ex_register (
	input  logic                     i_clk,
	input  logic                     i_nrst,
	input  decode_pkg::ctrl_t        i_ctrl,
	input  decode_pkg::branch_kind_t i_branch,
	input  decode_pkg::operands_t    i_ops,
	input  decode_pkg::word_t        i_pc4,
	output decode_pkg::id_ex_t       o_id_ex
);

	import decode_pkg::*;

	id_ex_t next;

	// gather both decode halves
	always_comb begin
		next        = '0;
		next.ctrl   = i_ctrl;
		next.ops    = i_ops;
		next.pc4    = i_pc4;
		next.branch = i_branch;
	end

	// all-zero means no write, no memory access, BR_NONE
	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			o_id_ex <= '0;
		end else begin
			o_id_ex <= next;
		end
	end

	// execute relies on a clean write enable every cycle
	a_reg_write_known : assert property (
		@(posedge i_clk) disable iff (!i_nrst)
		!$isunknown(o_id_ex.ctrl.reg_write)
	) else $error("registered reg_write unknown");

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
/*
 * decode stage top level
 * - control decoder and operand unit side by side
 * - decode/execute register for the execute stage
 * - combinational jump outputs and fetch stall
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decode_stage (
	input  logic                   i_clk,
	input  logic                   i_nrst,
	input  decode_pkg::word_t      i_pc4,
	input  decode_pkg::word_t      i_instr,
	input  decode_pkg::wb_port_t   i_wb,
	input  decode_pkg::hazard_t    i_hazard,
	output decode_pkg::id_ex_t     o_id_ex,
	output decode_pkg::jump_kind_t o_jump_kind,
	output decode_pkg::word_t      o_jump_target,
	output decode_pkg::word_t      o_jr_target,
	output logic                   o_ifstall
);

	import decode_pkg::*;

	ctrl_t        ctrl;
	branch_kind_t branch;
	logic         sign_ext;
	operands_t    ops;

	control_decoder control_decoder_inst (
		.i_instr    (i_instr),
		.o_ctrl     (ctrl),
		.o_branch   (branch),
		.o_jump     (o_jump_kind),
		.o_sign_ext (sign_ext),
		.o_ifstall  (o_ifstall)
	);

	operand_unit operand_unit_inst (
		.i_clk      (i_clk),
		.i_nrst     (i_nrst),
		.i_instr    (i_instr),
		.i_pc4      (i_pc4),
		.i_sign_ext (sign_ext),
		.i_wb       (i_wb),
		.i_hazard   (i_hazard),
		.o_ops      (ops)
	);

	id_ex_register id_ex_register_inst (
		.i_clk    (i_clk),
		.i_nrst   (i_nrst),
		.i_ctrl   (ctrl),
		.i_branch (branch),
		.i_ops    (ops),
		.i_pc4    (i_pc4),
		.o_id_ex  (o_id_ex)
	);

	// pseudo-direct target, region bits of pc+4 kept
	assign o_jump_target = {i_pc4[`DATA_W-1 -: 4], i_instr[25:0], 2'b00};

	// jr goes straight to the rs value
	assign o_jr_target = ops.rs_data;

endmodule

`default_nettype wire

// File: verification/tb_decode_stage.sv
/*
 * testbench of the decode stage
 * - reference decode model for control, jumps, immediates, forwarding
 * - register bank model for read-back checks
 * - one check task, one task per directed test
 */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module tb_decode_stage;

	import decode_pkg::*;

	localparam int CLK_PERIOD = 20;

	logic     clk = 1'b0;
	logic     nrst;
	word_t    pc4;
	word_t    instr;
	wb_port_t wb;
	hazard_t  hazard;

	id_ex_t     id_ex;
	jump_kind_t jump_kind;
	word_t      jump_target;
	word_t      jr_target;
	logic       ifstall;

	int    error_count = 0;
	int    check_count = 0;
	int    test_count  = 0;
	// expected register contents
	word_t model_regs [0:`REG_COUNT-1];

	always #(CLK_PERIOD / 2) clk = ~clk;

	decode_stage decode_stage_inst (
		.i_clk         (clk),
		.i_nrst        (nrst),
		.i_pc4         (pc4),
		.i_instr       (instr),
		.i_wb          (wb),
		.i_hazard      (hazard),
		.o_id_ex       (id_ex),
		.o_jump_kind   (jump_kind),
		.o_jump_target (jump_target),
		.o_jr_target   (jr_target),
		.o_ifstall     (ifstall)
	);

	// ========================================================================
	// reference model
	// ========================================================================
	function automatic ctrl_t model_ctrl(input word_t ins);
		ctrl_t      c;
		logic [5:0] op;
		logic       is_r;
		logic       is_load;
		logic       is_imm;
		op      = ins[31:26];
		c       = '0;
		// all-zero word is the nop, jr writes nothing
		is_r    = (op == `OP_RTYPE) && (ins[5:0] != `FN_JR) && (ins != '0);
		is_load = op inside {`OP_LB, `OP_LH, `OP_LW};
		is_imm  = op inside {`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI};
		if (is_r) begin
			c.alu_op = ins[5:0];
		end else if (is_load || is_imm || (op inside {`OP_SW, `OP_BEQ, `OP_BNE,
				`OP_J, `OP_JAL})) begin
			c.alu_op = op;
		end
		c.alu_src    = is_imm || is_load || (op == `OP_SW);
		c.reg_dst    = is_r;
		c.mem_read   = is_load;
		c.mem_write  = (op == `OP_SW);
		c.load_kind  = (op == `OP_LB) ? LOAD_BYTE : (op == `OP_LH) ? LOAD_HALF : LOAD_WORD;
		c.mem_to_reg = is_load;
		c.reg_write  = is_r || is_imm || is_load || (op == `OP_JAL);
		c.link       = (op == `OP_JAL);
		return c;
	endfunction

	function automatic branch_kind_t model_branch(input word_t ins);
		if (ins[31:26] == `OP_BEQ) return BR_EQ;
		if (ins[31:26] == `OP_BNE) return BR_NE;
		return BR_NONE;
	endfunction

	function automatic jump_kind_t model_jump(input word_t ins);
		if (ins[31:26] == `OP_J) return JMP_J;
		if (ins[31:26] == `OP_JAL) return JMP_JAL;
		if ((ins[31:26] == `OP_RTYPE) && (ins[5:0] == `FN_JR)) return JMP_JR;
		return JMP_NONE;
	endfunction

	// andi and ori zero extend, everything else sign extends
	function automatic word_t model_ext(input word_t ins);
		if ((ins[31:26] == `OP_ANDI) || (ins[31:26] == `OP_ORI)) begin
			return {16'h0000, ins[15:0]};
		end
		return {{16{ins[15]}}, ins[15:0]};
	endfunction

	function automatic fwd_sel_t model_fwd(input reg_addr_t src, input hazard_t hz);
		if ((src != '0) && hz.exe_reg_write && (hz.exe_dst == src)) return FWD_EXE;
		if ((src != '0) && hz.mem_reg_write && (hz.mem_dst == src)) return FWD_MEM;
		return FWD_REG;
	endfunction

	function automatic word_t make_r(input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd, input logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t make_i(input logic [5:0] op, input reg_addr_t rs,
			input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic reg_addr_t rand_reg();
		return reg_addr_t'($urandom);
	endfunction

	// ========================================================================
	// helpers
	// ========================================================================
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// bounded wait for a number of falling edges
	task automatic wait_falling(input int cycles);
		int seen;
		seen = 0;
		fork
			while (seen < cycles) begin
				@(negedge clk);
				seen++;
			end
			#(cycles * CLK_PERIOD + 5);
		join_any
		disable fork;
		if (seen < cycles) begin
			$display("timeout: clock gave no falling edge within %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_count++;
		$display("test %s: %s, %0d errors", name,
			(error_count == errs_before) ? "ok" : "FAILED", error_count - errs_before);
	endtask

	task automatic drive(input word_t ins, input word_t pc);
		instr = ins;
		pc4   = pc;
	endtask

	task automatic write_reg(input reg_addr_t addr, input word_t data);
		wb.we   = 1'b1;
		wb.addr = addr;
		wb.data = data;
		// r0 is hard-wired
		if (addr != '0) model_regs[addr] = data;
	endtask

	task automatic check_idle();
		check_value("o_id_ex.ctrl.reg_write", id_ex.ctrl.reg_write, 1'b0);
		check_value("o_id_ex.ctrl.mem_read", id_ex.ctrl.mem_read, 1'b0);
		check_value("o_id_ex.ctrl.mem_write", id_ex.ctrl.mem_write, 1'b0);
		check_value("o_id_ex.ctrl.link", id_ex.ctrl.link, 1'b0);
		check_value("o_id_ex.branch", id_ex.branch, BR_NONE);
	endtask

	// decode one word, compare the registered bundle a cycle later
	task automatic decode_and_check(input word_t ins);
		word_t pc;
		pc = $urandom;
		drive(ins, pc);
		wait_falling(1);
		check_value("o_id_ex.ctrl", id_ex.ctrl, model_ctrl(ins));
		check_value("o_id_ex.branch", id_ex.branch, model_branch(ins));
		check_value("o_id_ex.pc4", id_ex.pc4, pc);
		check_value("o_id_ex.ops.rt_addr", id_ex.ops.rt_addr, ins[20:16]);
		check_value("o_id_ex.ops.rd_addr", id_ex.ops.rd_addr, ins[15:11]);
	endtask

	task automatic run_fwd_case(input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t exe_dst, input logic exe_we,
			input reg_addr_t mem_dst, input logic mem_we);
		hazard.exe_dst       = exe_dst;
		hazard.exe_reg_write = exe_we;
		hazard.mem_dst       = mem_dst;
		hazard.mem_reg_write = mem_we;
		drive(make_r(rs, rt, 5'd4, 6'h20), 32'h0);
		wait_falling(1);
		check_value("o_id_ex.ops.fwd_a", id_ex.ops.fwd_a, model_fwd(rs, hazard));
		check_value("o_id_ex.ops.fwd_b", id_ex.ops.fwd_b, model_fwd(rt, hazard));
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic test_reset();
		int errs;
		errs = error_count;
		nrst = 1'b0;
		// a store waiting at the input must not leak through
		drive(make_i(`OP_SW, 5'd1, 5'd2, 16'h0010), 32'h0000_1000);
		wait_falling(4);
		check_idle();
		nrst = 1'b1;
		drive('0, 32'h0000_1004);
		wait_falling(1);
		check_idle();
		finish_test("reset", errs);
	endtask

	task automatic test_register_bank();
		int        errs;
		reg_addr_t addr [0:7];
		word_t     data;
		errs = error_count;
		// random writes while nops decode
		for (int i = 0; i < 8; i++) begin
			addr[i] = 1 + ($urandom % 31);
			write_reg(addr[i], $urandom);
			drive('0, 32'h0);
			wait_falling(1);
		end
		wb.we = 1'b0;
		for (int i = 0; i < 8; i++) begin
			drive(make_r(addr[i], addr[7-i], 5'd3, 6'h20), 32'h0);
			wait_falling(1);
			check_value("o_id_ex.ops.rs_data", id_ex.ops.rs_data, model_regs[addr[i]]);
			check_value("o_id_ex.ops.rt_data", id_ex.ops.rt_data, model_regs[addr[7-i]]);
		end
		// write to r0 is dropped
		write_reg(5'd0, 32'hdead_beef);
		wait_falling(1);
		wb.we = 1'b0;
		drive(make_r(5'd0, 5'd0, 5'd3, 6'h20), 32'h0);
		wait_falling(1);
		check_value("o_id_ex.ops.rs_data", id_ex.ops.rs_data, 32'h0);
		check_value("o_id_ex.ops.rt_data", id_ex.ops.rt_data, 32'h0);
		// read in the same cycle as the write sees the new data
		data = $urandom;
		write_reg(addr[0], data);
		drive(make_r(addr[0], addr[0], 5'd3, 6'h20), 32'h0);
		wait_falling(1);
		wb.we = 1'b0;
		check_value("o_id_ex.ops.rs_data", id_ex.ops.rs_data, data);
		check_value("o_id_ex.ops.rt_data", id_ex.ops.rt_data, data);
		finish_test("register_bank", errs);
	endtask

	task automatic test_control();
		int         errs;
		logic [5:0] op_list [0:12] = '{`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_LUI,
			`OP_LB, `OP_LH, `OP_LW, `OP_SW, `OP_BEQ, `OP_BNE, `OP_J, `OP_JAL};
		logic [5:0] fn;
		errs = error_count;
		foreach (op_list[i]) begin
			decode_and_check(make_i(op_list[i], rand_reg(), rand_reg(), 16'($urandom)));
		end
		// r-type with random function, jr belongs to the jump test
		for (int i = 0; i < 6; i++) begin
			fn = 6'($urandom);
			if (fn == `FN_JR) begin
				fn = 6'h21;
			end
			decode_and_check(make_r(rand_reg(), rand_reg(), rand_reg(), fn));
		end
		// outside the subset, then the fetch nop
		decode_and_check(make_i(6'h3f, rand_reg(), rand_reg(), 16'($urandom)));
		decode_and_check(make_i(6'h11, rand_reg(), rand_reg(), 16'($urandom)));
		decode_and_check('0);
		finish_test("control", errs);
	endtask

	task automatic test_jumps();
		int    errs;
		word_t ins [0:4];
		word_t pc;
		errs   = error_count;
		// known nonzero value behind the jr source register
		write_reg(5'd17, $urandom | 32'h1);
		wait_falling(1);
		wb.we  = 1'b0;
		ins[0] = make_i(`OP_J, rand_reg(), rand_reg(), 16'($urandom));
		ins[1] = make_i(`OP_JAL, rand_reg(), rand_reg(), 16'($urandom));
		ins[2] = make_r(5'd17, 5'd0, 5'd0, `FN_JR);
		ins[3] = make_i(`OP_BNE, rand_reg(), rand_reg(), 16'($urandom));
		ins[4] = make_i(`OP_ADDI, rand_reg(), rand_reg(), 16'($urandom));
		foreach (ins[i]) begin
			pc = $urandom;
			drive(ins[i], pc);
			// combinational outputs, settled inside the low phase
			#2;
			check_value("o_jump_kind", jump_kind, model_jump(ins[i]));
			check_value("o_ifstall", ifstall,
				(model_branch(ins[i]) != BR_NONE) || (model_jump(ins[i]) != JMP_NONE));
			check_value("o_jump_target", jump_target, {pc[31:28], ins[i][25:0], 2'b00});
			check_value("o_jr_target", jr_target, model_regs[ins[i][25:21]]);
			wait_falling(1);
		end
		finish_test("jumps", errs);
	endtask

	task automatic test_immediates();
		int         errs;
		logic [5:0] op_list [0:3] = '{`OP_ANDI, `OP_ORI, `OP_ADDI, `OP_BEQ};
		word_t      ins;
		word_t      pc;
		word_t      ext;
		errs = error_count;
		for (int i = 0; i < 12; i++) begin
			ins = make_i(op_list[i % 4], rand_reg(), rand_reg(), 16'($urandom));
			pc  = $urandom;
			drive(ins, pc);
			wait_falling(1);
			ext = model_ext(ins);
			check_value("o_id_ex.ops.imm_ext", id_ex.ops.imm_ext, ext);
			check_value("o_id_ex.ops.branch_target", id_ex.ops.branch_target, pc + (ext << 2));
		end
		finish_test("immediates", errs);
	endtask

	task automatic test_forwarding();
		int errs;
		errs = error_count;
		run_fwd_case(5'd5, 5'd9, 5'd5, 1'b1, 5'd0, 1'b0);
		run_fwd_case(5'd5, 5'd9, 5'd0, 1'b0, 5'd9, 1'b1);
		// execute beats memory
		run_fwd_case(5'd5, 5'd9, 5'd5, 1'b1, 5'd5, 1'b1);
		run_fwd_case(5'd5, 5'd9, 5'd9, 1'b1, 5'd5, 1'b1);
		// r0 never forwards
		run_fwd_case(5'd0, 5'd0, 5'd0, 1'b1, 5'd0, 1'b1);
		// idle writers
		run_fwd_case(5'd5, 5'd9, 5'd5, 1'b0, 5'd9, 1'b0);
		// small index range makes collisions likely
		for (int i = 0; i < 8; i++) begin
			run_fwd_case(5'($urandom % 4), 5'($urandom % 4), 5'($urandom % 4),
				1'($urandom), 5'($urandom % 4), 1'($urandom));
		end
		hazard = '0;
		finish_test("forwarding", errs);
	endtask

	initial begin
		void'($urandom(98256));
		nrst   = 1'b0;
		pc4    = '0;
		instr  = '0;
		wb     = '0;
		hazard = '0;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		test_reset();
		test_register_bank();
		test_control();
		test_jumps();
		test_immediates();
		test_forwarding();
		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/control_decoder.sv
rtl/register_bank.sv
rtl/operand_unit.sv
rtl/id_ex_register.sv
rtl/decode_stage.sv
verification/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - rtl

sources:
  - rtl/decode_pkg.sv
  - rtl/control_decoder.sv
  - rtl/register_bank.sv
  - rtl/operand_unit.sv
  - rtl/id_ex_register.sv
  - rtl/decode_stage.sv
  - target: test
    files:
      - verification/tb_decode_stage.sv
